// ==== src/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

  ////////////////////
  // Bus geometry
  ////////////////////
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int be_w   = 4;

  // Byte offset bits below the word index
  localparam int word_lsb = $clog2(be_w);

  ////////////////////
  // Cache geometry
  ////////////////////
  localparam int num_ways   = 4;
  localparam int way_w      = $clog2(num_ways);
  localparam int line_words = 16;

  // Word index within one way, address bits 10 to 2
  localparam int word_idx_w = 9;
  // Set index is the word index without the word-in-line bits
  localparam int set_idx_w  = word_idx_w - $clog2(line_words);
  localparam int set_lsb    = word_lsb + $clog2(line_words);
  localparam int tag_lsb    = word_lsb + word_idx_w;
  localparam int tag_w      = addr_w - tag_lsb;

  typedef logic [way_w-1:0]      way_t;
  typedef logic [word_idx_w-1:0] word_idx_t;
  typedef logic [set_idx_w-1:0]  set_idx_t;

endpackage

// ==== src/cache_req_pkg.sv ====
package cache_req_pkg;

  import cache_cfg_pkg::*;

  ////////////////////
  // Bus request
  ////////////////////
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [be_w-1:0]   be;
    logic              read;
    logic              write;
    logic [data_w-1:0] wdata;
  } cache_req_t;

  ////////////////////
  // Tag RAM entry
  ////////////////////
  typedef struct packed {
    logic             valid;
    logic [tag_w-1:0] tag;
  } tag_entry_t;

  // Command level towards the refill agent, held until refill_done
  typedef enum logic [1:0] {
    cmd_nop  = 2'd0,
    cmd_fill = 2'd1,
    cmd_io   = 2'd2
  } refill_cmd_e;

endpackage

// ==== src/cache_if.sv ====
`timescale 1ns/1ps

// Accepted request and the last accepted cacheable write
interface cache_req_if
  import cache_req_pkg::*;
();

  cache_req_t cur;
  logic       cur_valid;
  cache_req_t prev;
  logic       prev_valid;

  modport stage (output cur, output cur_valid, output prev, output prev_valid);
  modport user  (input cur, input cur_valid, input prev, input prev_valid);

endinterface

// Line fill writes from the refill agent into the tag and data RAMs
interface cache_fill_if
  import cache_cfg_pkg::*;
();

  logic              we;
  logic              tag_we;
  way_t              way;
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] data;

  modport host (output we, output tag_we, output way, output addr, output data);
  modport ram  (input we, input tag_we, input way, input addr, input data);

endinterface

// ==== src/cache_req_stage.sv ====
`timescale 1ns/1ps

module cache_req_stage
  import cache_cfg_pkg::*;
(
  input  logic              clk,
  input  logic              rest,
  input  logic [addr_w-1:0] addr,
  input  logic [be_w-1:0]   be,
  input  logic              read,
  input  logic              write,
  input  logic [data_w-1:0] wdata,
  input  logic              io_addr,
  input  logic              wait_req,
  cache_req_if.stage        req,
  output logic              cur_io
);

  logic accept;
  logic keep_write;

  assign accept = (read || write) && !wait_req;

  // Only cacheable writes can be forwarded into a later read
  assign keep_write = req.cur.write && !cur_io;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      req.cur_valid  <= 1'b0;
      req.prev_valid <= 1'b0;
      req.cur        <= '0;
      cur_io         <= 1'b0;
    end else begin
      // A cycle without stall either takes a new request or leaves the stage empty
      if (!wait_req) begin
        req.cur_valid <= read || write;
      end
      if (accept) begin
        req.cur <= '{addr: addr, be: be, read: read, write: write, wdata: wdata};
        cur_io  <= io_addr;
        if (keep_write) begin
          req.prev_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && keep_write) begin
      req.prev <= req.cur;
    end
  end

  a_rw_exclusive: assert property (@(posedge clk) disable iff (!rest) !(read && write));

endmodule

// ==== src/cache_way_ram.sv ====
`timescale 1ns/1ps

module cache_way_ram
  import cache_cfg_pkg::*;
  import cache_req_pkg::*;
#(
  parameter type entry_t = tag_entry_t,
  parameter int  depth   = 1 << set_idx_w
) (
  input  logic                     clk,
  input  logic [$clog2(depth)-1:0] rd_idx,
  input  logic                     wr_en,
  input  way_t                     wr_way,
  input  logic [$clog2(depth)-1:0] wr_idx,
  input  entry_t                   wr_entry,
  output entry_t                   rd_entries [num_ways]
);

  ////////////////////
  // One memory per way
  ////////////////////
  for (genvar w = 0; w < num_ways; w++) begin : g_way
    entry_t mem [depth];

    always_ff @(posedge clk) begin
      if (wr_en && wr_way == way_t'(w)) begin
        mem[wr_idx] <= wr_entry;
      end
      // A read of the entry being written returns the old contents
      rd_entries[w] <= mem[rd_idx];
    end
  end

endmodule

// ==== src/cache_tag_store.sv ====
`timescale 1ns/1ps

module cache_tag_store
  import cache_cfg_pkg::*;
  import cache_req_pkg::*;
(
  input  logic      clk,
  input  logic      rest,
  input  set_idx_t  lookup_set,
  cache_req_if.user req,
  cache_fill_if.ram fill,
  output logic      hit,
  output way_t      hit_way,
  output logic      has_free,
  output way_t      free_way
);

  localparam int sweep_w = set_idx_w + way_w;

  logic [sweep_w-1:0]  sweep_cnt;
  logic                sweep_busy;
  tag_entry_t          rd_tags [num_ways];
  logic                wr_en;
  way_t                wr_way;
  set_idx_t            wr_set;
  tag_entry_t          wr_tag;
  logic [num_ways-1:0] swept_q;
  logic [num_ways-1:0] valid_vec;
  logic [num_ways-1:0] hit_vec;
  logic [tag_w-1:0]    cur_tag;

  ////////////////////
  // Reset sweep
  ////////////////////
  // Walks every set and way once and writes an invalid entry; fill writes take priority
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      sweep_cnt  <= '0;
      sweep_busy <= 1'b1;
      swept_q    <= '0;
    end else begin
      if (sweep_busy && !fill.tag_we) begin
        sweep_cnt <= sweep_cnt + 1'b1;
        if (&sweep_cnt) begin
          sweep_busy <= 1'b0;
        end
      end
      // Entries the sweep has not reached yet read as invalid
      for (int w = 0; w < num_ways; w++) begin
        swept_q[w] <= !sweep_busy || ({lookup_set, way_t'(w)} < sweep_cnt);
      end
    end
  end

  assign wr_en  = fill.tag_we || sweep_busy;
  assign wr_way = fill.tag_we ? fill.way : sweep_cnt[way_w-1:0];
  assign wr_set = fill.tag_we ? fill.addr[tag_lsb-1:set_lsb] : sweep_cnt[sweep_w-1:way_w];
  assign wr_tag = fill.tag_we ? '{valid: 1'b1, tag: fill.addr[addr_w-1:tag_lsb]} : '0;

  cache_way_ram #(
    .entry_t (tag_entry_t),
    .depth   (1 << set_idx_w)
  ) tag_ram_i (
    .clk        (clk),
    .rd_idx     (lookup_set),
    .wr_en      (wr_en),
    .wr_way     (wr_way),
    .wr_idx     (wr_set),
    .wr_entry   (wr_tag),
    .rd_entries (rd_tags)
  );

  ////////////////////
  // Compare
  ////////////////////
  assign cur_tag = req.cur.addr[addr_w-1:tag_lsb];

  always_comb begin
    hit_way  = '0;
    free_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      valid_vec[w] = rd_tags[w].valid && swept_q[w];
      hit_vec[w]   = valid_vec[w] && (rd_tags[w].tag == cur_tag);
    end
    // Lowest numbered way wins in both encoders
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = way_t'(w);
      end
      if (!valid_vec[w]) begin
        free_way = way_t'(w);
      end
    end
  end

  assign hit      = |hit_vec;
  assign has_free = !(&valid_vec);

  a_one_hit: assert property (@(posedge clk) disable iff (!rest)
    req.cur_valid |-> $onehot0(hit_vec));

endmodule

// ==== src/cache_read_merge.sv ====
`timescale 1ns/1ps

module cache_read_merge
  import cache_cfg_pkg::*;
(
  input  logic [data_w-1:0] way_words [num_ways],
  input  way_t              hit_way,
  cache_req_if.user         req,
  output logic [data_w-1:0] hit_word,
  output logic [data_w-1:0] merged_word
);

  logic [data_w-1:0] ram_word;
  logic              fwd;

  assign ram_word = way_words[hit_way];

  // The previous write may have landed in the RAM in the same cycle as this read
  assign fwd = req.prev_valid &&
               (req.prev.addr[addr_w-1:word_lsb] == req.cur.addr[addr_w-1:word_lsb]);

  ////////////////////
  // Byte lanes
  ////////////////////
  always_comb begin
    hit_word = ram_word;
    for (int b = 0; b < be_w; b++) begin
      if (fwd && req.prev.be[b]) begin
        hit_word[8*b +: 8] = req.prev.wdata[8*b +: 8];
      end
    end
    // A write hit stores the current line word with its own enabled bytes on top
    merged_word = hit_word;
    for (int b = 0; b < be_w; b++) begin
      if (req.cur.be[b]) begin
        merged_word[8*b +: 8] = req.cur.wdata[8*b +: 8];
      end
    end
  end

endmodule

// ==== src/cache_hit_ctrl.sv ====
`timescale 1ns/1ps

module cache_hit_ctrl
  import cache_cfg_pkg::*;
  import cache_req_pkg::*;
(
  input  logic              clk,
  input  logic              rest,
  cache_req_if.user         req,
  input  logic              cur_io,
  input  logic              hit,
  input  logic              has_free,
  input  way_t              free_way,
  input  logic [data_w-1:0] hit_word,
  input  logic              refill_done,
  input  logic [data_w-1:0] refill_rdata,
  output logic              wait_req,
  output logic              read_valid,
  output logic [data_w-1:0] read_data,
  output logic              data_we,
  output refill_cmd_e       refill_cmd,
  output logic [addr_w-1:0] refill_addr,
  output logic [be_w-1:0]   refill_be,
  output logic              refill_write,
  output logic [data_w-1:0] refill_wdata,
  output way_t              refill_way
);

  typedef enum logic [1:0] {st_idle, st_fill_wait, st_io_wait, st_replay} state_e;

  state_e state;
  state_e state_nxt;
  logic   served;
  logic   pend;
  logic   idle_active;
  logic   need_fill;
  logic   need_io;
  logic   lookup_hit;
  way_t   victim;
  way_t   rr_way;
  way_t   fill_way_q;

  ////////////////////
  // Decisions
  ////////////////////
  // An IO request that already completed must not be issued again
  assign pend        = req.cur_valid && !served;
  assign idle_active = (state == st_idle) && pend;
  assign need_io     = idle_active && cur_io;
  assign need_fill   = idle_active && !cur_io && !hit;
  assign lookup_hit  = idle_active && !cur_io && hit;
  assign victim      = has_free ? free_way : rr_way;

  assign wait_req   = need_io || need_fill || (state != st_idle);
  assign data_we    = lookup_hit && req.cur.write;
  assign read_valid = (lookup_hit && req.cur.read) ||
                      ((state == st_io_wait) && refill_done && req.cur.read);
  assign read_data  = (state == st_io_wait) ? refill_rdata : hit_word;

  // The stage holds cur during a stall, so these stay steady with the command
  assign refill_addr  = req.cur.addr;
  assign refill_be    = req.cur.be;
  assign refill_write = req.cur.write;
  assign refill_wdata = req.cur.wdata;
  assign refill_way   = (state == st_fill_wait) ? fill_way_q : victim;

  always_comb begin
    state_nxt  = state;
    refill_cmd = cmd_nop;
    case (state)
      st_idle: begin
        if (need_fill) begin
          refill_cmd = cmd_fill;
          state_nxt  = st_fill_wait;
        end else if (need_io) begin
          refill_cmd = cmd_io;
          state_nxt  = st_io_wait;
        end
      end
      st_fill_wait: begin
        refill_cmd = cmd_fill;
        if (refill_done) begin
          state_nxt = st_replay;
        end
      end
      st_io_wait: begin
        refill_cmd = cmd_io;
        if (refill_done) begin
          state_nxt = st_idle;
        end
      end
      default: begin
        // Replay rereads the lookup so the next idle cycle sees the loaded line
        state_nxt = st_idle;
      end
    endcase
  end

  ////////////////////
  // State
  ////////////////////
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state  <= st_idle;
      served <= 1'b0;
      rr_way <= '0;
    end else begin
      state <= state_nxt;
      if ((state == st_io_wait) && refill_done) begin
        served <= 1'b1;
      end else if (!wait_req) begin
        served <= 1'b0;
      end
      if (need_fill && !has_free) begin
        rr_way <= rr_way + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (need_fill) begin
      fill_way_q <= victim;
    end
  end

  a_cmd_steady: assert property (@(posedge clk) disable iff (!rest)
    (refill_cmd != cmd_nop && !refill_done) |=> (refill_cmd == $past(refill_cmd)));

endmodule

// ==== src/cache_rw.sv ====
`timescale 1ns/1ps

module cache_rw
  import cache_cfg_pkg::*;
  import cache_req_pkg::*;
(
  input  logic              clk,
  input  logic              rest,
  input  logic [addr_w-1:0] addr,
  input  logic [be_w-1:0]   be,
  input  logic              read,
  input  logic              write,
  input  logic [data_w-1:0] wdata,
  input  logic              io_addr,
  input  logic              refill_done,
  input  logic [data_w-1:0] refill_rdata,
  input  logic              fill_we,
  input  logic              fill_tag_we,
  input  way_t              fill_way,
  input  logic [addr_w-1:0] fill_addr,
  input  logic [data_w-1:0] fill_data,
  output logic [data_w-1:0] read_data,
  output logic              read_valid,
  output logic              wait_req,
  output refill_cmd_e       refill_cmd,
  output logic [addr_w-1:0] refill_addr,
  output logic [be_w-1:0]   refill_be,
  output logic              refill_write,
  output logic [data_w-1:0] refill_wdata,
  output way_t              refill_way
);

  cache_req_if  req_bus ();
  cache_fill_if fill_bus ();

  logic [addr_w-1:0] lookup_addr;
  set_idx_t          lookup_set;
  word_idx_t         lookup_word;
  logic              cur_io;
  logic              hit;
  way_t              hit_way;
  logic              has_free;
  way_t              free_way;
  logic [data_w-1:0] way_words [num_ways];
  logic [data_w-1:0] hit_word;
  logic [data_w-1:0] merged_word;
  logic              data_we;
  logic              fill_sel;
  logic              data_wr_en;
  way_t              data_wr_way;
  word_idx_t         data_wr_idx;
  logic [data_w-1:0] data_wr_word;

  ////////////////////
  // Wiring
  ////////////////////
  assign fill_bus.we     = fill_we;
  assign fill_bus.tag_we = fill_tag_we;
  assign fill_bus.way    = fill_way;
  assign fill_bus.addr   = fill_addr;
  assign fill_bus.data   = fill_data;

  // During a stall the RAMs keep reading the held request
  assign lookup_addr = wait_req ? req_bus.cur.addr : addr;
  assign lookup_set  = lookup_addr[tag_lsb-1:set_lsb];
  assign lookup_word = lookup_addr[tag_lsb-1:word_lsb];

  // Fill data owns the data RAM write port while a line is loading
  assign fill_sel     = (refill_cmd == cmd_fill);
  assign data_wr_en   = fill_sel ? fill_bus.we : data_we;
  assign data_wr_way  = fill_sel ? fill_bus.way : hit_way;
  assign data_wr_idx  = fill_sel ? fill_bus.addr[tag_lsb-1:word_lsb]
                                 : req_bus.cur.addr[tag_lsb-1:word_lsb];
  assign data_wr_word = fill_sel ? fill_bus.data : merged_word;

  cache_req_stage stage_i (
    .clk      (clk),
    .rest     (rest),
    .addr     (addr),
    .be       (be),
    .read     (read),
    .write    (write),
    .wdata    (wdata),
    .io_addr  (io_addr),
    .wait_req (wait_req),
    .req      (req_bus.stage),
    .cur_io   (cur_io)
  );

  cache_tag_store tags_i (
    .clk        (clk),
    .rest       (rest),
    .lookup_set (lookup_set),
    .req        (req_bus.user),
    .fill       (fill_bus.ram),
    .hit        (hit),
    .hit_way    (hit_way),
    .has_free   (has_free),
    .free_way   (free_way)
  );

  cache_way_ram #(
    .entry_t (logic [data_w-1:0]),
    .depth   (1 << word_idx_w)
  ) data_ram_i (
    .clk        (clk),
    .rd_idx     (lookup_word),
    .wr_en      (data_wr_en),
    .wr_way     (data_wr_way),
    .wr_idx     (data_wr_idx),
    .wr_entry   (data_wr_word),
    .rd_entries (way_words)
  );

  cache_read_merge merge_i (
    .way_words   (way_words),
    .hit_way     (hit_way),
    .req         (req_bus.user),
    .hit_word    (hit_word),
    .merged_word (merged_word)
  );

  cache_hit_ctrl ctrl_i (
    .clk          (clk),
    .rest         (rest),
    .req          (req_bus.user),
    .cur_io       (cur_io),
    .hit          (hit),
    .has_free     (has_free),
    .free_way     (free_way),
    .hit_word     (hit_word),
    .refill_done  (refill_done),
    .refill_rdata (refill_rdata),
    .wait_req     (wait_req),
    .read_valid   (read_valid),
    .read_data    (read_data),
    .data_we      (data_we),
    .refill_cmd   (refill_cmd),
    .refill_addr  (refill_addr),
    .refill_be    (refill_be),
    .refill_write (refill_write),
    .refill_wdata (refill_wdata),
    .refill_way   (refill_way)
  );

endmodule

// ==== sim/cache_rw_tb.sv ====
`timescale 1ns/1ps

module cache_rw_tb
  import cache_cfg_pkg::*;
  import cache_req_pkg::*;
();

  localparam int set_a      = 3;
  localparam int set_b      = 17;
  localparam int tag_base   = 'h12;
  localparam int max_wait   = 300;
  localparam int num_random = 400;

  // Refill agent phases
  localparam int ag_idle  = 0;
  localparam int ag_delay = 1;
  localparam int ag_words = 2;
  localparam int ag_tag   = 3;
  localparam int ag_done  = 4;

  logic              clk;
  logic              rest;
  logic [addr_w-1:0] addr;
  logic [be_w-1:0]   be;
  logic              read;
  logic              write;
  logic [data_w-1:0] wdata;
  logic              io_addr;
  logic              refill_done;
  logic [data_w-1:0] refill_rdata;
  logic              fill_we;
  logic              fill_tag_we;
  way_t              fill_way;
  logic [addr_w-1:0] fill_addr;
  logic [data_w-1:0] fill_data;
  logic [data_w-1:0] read_data;
  logic              read_valid;
  logic              wait_req;
  refill_cmd_e       refill_cmd;
  logic [addr_w-1:0] refill_addr;
  logic [be_w-1:0]   refill_be;
  logic              refill_write;
  logic [data_w-1:0] refill_wdata;
  way_t              refill_way;

  // Models: 8 lines, five in set_a and three in set_b, plus 16 IO words
  logic [31:0] lfsr;
  logic [31:0] mem_model [128];
  logic [31:0] io_ref [16];
  logic [31:0] io_mem [16];
  int          value_errors;
  int          proto_errors;
  int          timeouts;

  // Which test line sits in each way of the two sets, -1 when free
  int          way_line [2][4];
  int          rr_next;

  logic        drv_read;
  logic        drv_write;
  logic [31:0] drv_addr;
  logic [3:0]  drv_be;
  logic [31:0] drv_wdata;
  logic        wait_seen;

  // The request in flight
  logic        pend_valid;
  logic        pend_read;
  logic        pend_write;
  logic        pend_seen;
  logic        pend_fast;
  logic [31:0] pend_exp;
  logic [31:0] pend_addr;
  logic [3:0]  pend_be;
  logic [31:0] pend_wdata;
  string       pend_name;
  int          pend_age;
  int          pend_cmds;
  int          pend_want;

  int          ag_state;
  int          ag_cnt;
  int          ag_line;
  way_t        ag_way;
  logic        ag_io;
  logic [31:0] ag_addr;
  logic [3:0]  ag_be;
  logic        ag_write;
  logic [31:0] ag_wdata;

  cache_rw dut_i (
    .clk          (clk),
    .rest         (rest),
    .addr         (addr),
    .be           (be),
    .read         (read),
    .write        (write),
    .wdata        (wdata),
    .io_addr      (io_addr),
    .refill_done  (refill_done),
    .refill_rdata (refill_rdata),
    .fill_we      (fill_we),
    .fill_tag_we  (fill_tag_we),
    .fill_way     (fill_way),
    .fill_addr    (fill_addr),
    .fill_data    (fill_data),
    .read_data    (read_data),
    .read_valid   (read_valid),
    .wait_req     (wait_req),
    .refill_cmd   (refill_cmd),
    .refill_addr  (refill_addr),
    .refill_be    (refill_be),
    .refill_write (refill_write),
    .refill_wdata (refill_wdata),
    .refill_way   (refill_way)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic logic [31:0] line_base(input int line);
    logic [tag_w-1:0]     tg;
    logic [set_idx_w-1:0] st;
    if (line < 5) begin
      tg = tag_base + line;
      st = set_a;
    end else begin
      tg = tag_base + line - 5;
      st = set_b;
    end
    return {tg, st, 6'b0};
  endfunction

  function automatic int line_of(input logic [31:0] a);
    logic [31:0] base;
    int          found;
    found = -1;
    for (int l = 0; l < 8; l++) begin
      base = line_base(l);
      if (base[31:6] == a[31:6]) begin
        found = l;
      end
    end
    return found;
  endfunction

  function automatic logic [31:0] fill_pattern(input logic [31:0] a);
    return (a * 32'h0101_0107) ^ 32'hC3A5_5A3C;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                              input logic [3:0] b);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (b[i]) begin
        res[8*i +: 8] = nw[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    value_errors++;
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
  endtask

  task automatic report_error(input string msg);
    proto_errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic finish_run();
    $display("errors: %0d value, %0d protocol, %0d timeout", value_errors, proto_errors, timeouts);
    if (value_errors + proto_errors + timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  task automatic check_quiet(input string name);
    if (wait_req !== 1'b0) begin
      report_value({name, " wait_req"}, 0, wait_req);
    end
    if (read_valid !== 1'b0) begin
      report_value({name, " read_valid"}, 0, read_valid);
    end
    if (refill_cmd !== cmd_nop) begin
      report_value({name, " refill_cmd"}, cmd_nop, refill_cmd);
    end
  endtask

  // Victim rule: lowest free way of the set, otherwise the round-robin way
  task automatic check_victim(input int line);
    int s;
    int vw;
    s  = (line < 5) ? 0 : 1;
    vw = -1;
    for (int w = 3; w >= 0; w--) begin
      if (way_line[s][w] < 0) begin
        vw = w;
      end
    end
    if (vw < 0) begin
      vw      = rr_next;
      rr_next = (rr_next + 1) % 4;
    end
    if (refill_way !== way_t'(vw)) begin
      report_value({pend_name, " fill way"}, vw, refill_way);
    end
    way_line[s][vw] = line;
  endtask

  ////////////////////
  // Cycle engine
  ////////////////////
  task automatic drive_inputs();
    logic [3:0] word;
    logic [31:0] base;
    word  = ag_cnt[3:0];
    base  = line_base(ag_line);
    read  = drv_read;
    write = drv_write;
    addr  = drv_addr;
    be    = drv_be;
    wdata = drv_wdata;
    io_addr      = drv_addr[31];
    fill_we      = (ag_state == ag_words);
    fill_tag_we  = (ag_state == ag_tag);
    fill_way     = ag_way;
    fill_addr    = {base[31:6], word, 2'b00};
    fill_data    = mem_model[ag_line * line_words + int'(word)];
    refill_done  = (ag_state == ag_done);
    refill_rdata = io_mem[ag_addr[5:2]];
    // The IO device takes the write when it signals completion
    if (ag_state == ag_done && ag_io && ag_write) begin
      io_mem[ag_addr[5:2]] = merge_bytes(io_mem[ag_addr[5:2]], ag_wdata, ag_be);
    end
  endtask

  task automatic observe();
    refill_cmd_e want_cmd;
    wait_seen = wait_req;
    if (pend_valid) begin
      pend_age++;
    end
    if (read_valid === 1'b1) begin
      if (!pend_valid || !pend_read || pend_seen) begin
        report_error("read_valid without an outstanding read");
      end else begin
        pend_seen = 1'b1;
        if (read_data !== pend_exp) begin
          report_value(pend_name, pend_exp, read_data);
        end
        if (pend_fast && pend_age != 1) begin
          report_value({pend_name, " latency"}, 1, pend_age);
        end
      end
    end
    if (ag_state == ag_idle) begin
      if (refill_cmd == cmd_fill || refill_cmd == cmd_io) begin
        pend_cmds++;
        ag_io    = (refill_cmd == cmd_io);
        ag_addr  = refill_addr;
        ag_be    = refill_be;
        ag_write = refill_write;
        ag_wdata = refill_wdata;
        ag_way   = refill_way;
        ag_cnt   = 2 + int'(rand_bits(3) % 5);
        ag_state = ag_delay;
        if (!pend_valid) begin
          report_error("refill command without an accepted request");
        end else if (ag_io) begin
          if (refill_addr !== pend_addr) report_value({pend_name, " io addr"}, pend_addr, refill_addr);
          if (refill_be !== pend_be) report_value({pend_name, " io be"}, pend_be, refill_be);
          if (refill_write !== pend_write) begin
            report_value({pend_name, " io write flag"}, pend_write, refill_write);
          end
          if (pend_write && refill_wdata !== pend_wdata) begin
            report_value({pend_name, " io wdata"}, pend_wdata, refill_wdata);
          end
        end else begin
          if (refill_addr[31:6] !== pend_addr[31:6]) begin
            report_value({pend_name, " fill line"}, {pend_addr[31:6], 6'b0}, {refill_addr[31:6], 6'b0});
          end
          ag_line = line_of(refill_addr);
          if (ag_line < 0) begin
            report_error("fill requested for an address outside the test lines");
            ag_line = 0;
          end else begin
            check_victim(ag_line);
          end
        end
      end else if (refill_cmd !== cmd_nop) begin
        report_error("refill_cmd holds an undefined code");
      end
    end else begin
      want_cmd = ag_io ? cmd_io : cmd_fill;
      if (refill_cmd !== want_cmd) begin
        report_error("refill_cmd changed before refill_done");
      end
      if (!ag_io && refill_way !== ag_way) begin
        report_value({pend_name, " held fill way"}, ag_way, refill_way);
      end
      case (ag_state)
        ag_delay: begin
          ag_cnt--;
          if (ag_cnt == 0) ag_state = ag_io ? ag_done : ag_words;
        end
        ag_words: begin
          ag_cnt++;
          if (ag_cnt == line_words) ag_state = ag_tag;
        end
        ag_tag:  ag_state = ag_done;
        default: ag_state = ag_idle;
      endcase
    end
  endtask

  // Drive a cycle's inputs, then sample at the falling edge
  task automatic step();
    @(posedge clk);
    #2;
    drive_inputs();
    @(negedge clk);
    observe();
  endtask

  task automatic close_pending();
    if (pend_valid) begin
      if (pend_read && !pend_seen) begin
        report_error($sformatf("%s completed without read_valid", pend_name));
      end
      if (pend_want >= 0 && pend_cmds != pend_want) begin
        report_value({pend_name, " refill commands"}, pend_want, pend_cmds);
      end
    end
    pend_valid = 1'b0;
  endtask

  task automatic issue(input string name, input logic wr, input logic [31:0] a,
                       input logic [3:0] b, input logic [31:0] d, input int want,
                       input logic fast);
    int n;
    int idx;
    drv_read  = !wr;
    drv_write = wr;
    drv_addr  = a;
    drv_be    = b;
    drv_wdata = d;
    n         = 0;
    wait_seen = 1'b1;
    while (wait_seen && n < max_wait) begin
      step();
      n++;
    end
    if (wait_seen) begin
      timeouts++;
      $display("ERROR: timeout, %s was never accepted", name);
      finish_run();
    end
    // Accepted at the coming rising edge, so the previous access is complete
    close_pending();
    pend_valid = 1'b1;
    pend_read  = !wr;
    pend_write = wr;
    pend_seen  = 1'b0;
    pend_fast  = fast;
    pend_addr  = a;
    pend_be    = b;
    pend_wdata = d;
    pend_name  = name;
    pend_age   = 0;
    pend_cmds  = 0;
    if (a[31]) begin
      idx       = int'(a[5:2]);
      pend_exp  = io_ref[idx];
      pend_want = 1;
      if (wr) io_ref[idx] = merge_bytes(io_ref[idx], d, b);
    end else begin
      idx       = line_of(a) * line_words + int'(a[5:2]);
      pend_exp  = mem_model[idx];
      pend_want = want;
      if (wr) mem_model[idx] = merge_bytes(mem_model[idx], d, b);
    end
    drv_read  = 1'b0;
    drv_write = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (pend_valid && n < max_wait) begin
      step();
      n++;
      if (!wait_seen) close_pending();
    end
    if (pend_valid) begin
      timeouts++;
      $display("ERROR: timeout, %s did not complete", pend_name);
      finish_run();
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  b;
    logic        wr;
    lfsr         = 32'd92;
    value_errors = 0;
    proto_errors = 0;
    timeouts     = 0;
    rr_next      = 0;
    pend_valid   = 1'b0;
    ag_state     = ag_idle;
    ag_cnt       = 0;
    ag_line      = 0;
    ag_way       = '0;
    ag_io        = 1'b0;
    ag_addr      = '0;
    ag_be        = '0;
    ag_write     = 1'b0;
    ag_wdata     = '0;
    drv_read     = 1'b0;
    drv_write    = 1'b0;
    drv_addr     = '0;
    drv_be       = '0;
    drv_wdata    = '0;
    for (int s = 0; s < 2; s++) begin
      for (int w = 0; w < 4; w++) begin
        way_line[s][w] = -1;
      end
    end
    for (int l = 0; l < 8; l++) begin
      for (int w = 0; w < line_words; w++) begin
        mem_model[l * line_words + w] = fill_pattern(line_base(l) | (w << 2));
      end
    end
    for (int i = 0; i < 16; i++) begin
      io_ref[i] = fill_pattern(32'h8000_0000 | (i << 2));
      io_mem[i] = io_ref[i];
    end
    rest = 1'b0;
    drive_inputs();

    repeat (4) begin
      @(posedge clk);
      #1;
      check_quiet("during reset");
    end
    #1;
    rest = 1'b1;
    // The tag RAM clears its valid bits over the first 128 cycles
    for (int i = 0; i < 140; i++) begin
      step();
      check_quiet("after reset");
    end

    // Miss, then the same word again as a hit
    issue("read miss", 1'b0, line_base(0) | (5 << 2), 4'hf, 0, 1, 1'b0);
    issue("read hit", 1'b0, line_base(0) | (5 << 2), 4'hf, 0, 0, 1'b1);
    drain();

    // Byte-enabled write hit and a read of the same word right behind it
    a = line_base(6) | (3 << 2);
    issue("load for write", 1'b0, a, 4'hf, 0, 1, 1'b0);
    drain();
    issue("write hit", 1'b1, a, 4'b0101, 32'hDEAD_BEEF, 0, 1'b1);
    issue("forwarded read", 1'b0, a, 4'hf, 0, 0, 1'b1);
    drain();
    repeat (3) step();
    issue("later read", 1'b0, a, 4'hf, 0, 0, 1'b1);
    drain();

    // Five lines through one four-way set
    for (int p = 0; p < 2; p++) begin
      for (int l = 0; l < 5; l++) begin
        issue("eviction read", 1'b0, line_base(l) | (7 << 2), 4'hf, 0, -1, 1'b0);
      end
      issue("eviction write", 1'b1, line_base(2) | (7 << 2), 4'b1001, 32'h1234_5678, -1, 1'b0);
    end
    drain();

    // IO bypass
    a = 32'h8000_0000 | (9 << 2);
    issue("io write", 1'b1, a, 4'b1100, 32'hCAFE_F00D, 1, 1'b0);
    issue("io read", 1'b0, a, 4'hf, 0, 1, 1'b0);
    issue("io repeat read", 1'b0, a, 4'hf, 0, 1, 1'b0);
    drain();

    for (int i = 0; i < num_random; i++) begin
      a  = line_base(int'(rand_bits(3))) | (rand_bits(4) << 2);
      a[31] = (rand_bits(3) == 0);
      wr = rand_bits(1);
      b  = rand_bits(4);
      if (b == 4'h0) b = 4'hf;
      d  = rand_bits(32);
      issue("random", wr, a, b, d, -1, 1'b0);
      if (rand_bits(2) == 0) drain();
    end
    drain();
    finish_run();
  end

endmodule

// ==== vlog.f ====
src/cache_cfg_pkg.sv
src/cache_req_pkg.sv
src/cache_if.sv
src/cache_req_stage.sv
src/cache_way_ram.sv
src/cache_tag_store.sv
src/cache_read_merge.sv
src/cache_hit_ctrl.sv
src/cache_rw.sv
sim/cache_rw_tb.sv
